// ==== sources.f ====
logic/tap_pkg.sv
logic/frame_tick.sv
logic/ball_column.sv
logic/frame_sequencer.sv
logic/pixel_painter.sv
logic/tap_tapper.sv
tb/tap_tapper_assertions.sv
tb/tap_tapper_tb.sv

// ==== tb/tap_tapper_tb.sv ====
module tap_tapper_tb
	import tap_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int refresh_period = 25000; // longer than one frame
	localparam int max_cycles = 40 * refresh_period; // ~15 periods of tests plus end rasters

	logic clk;
	logic resetn;
	logic [num_columns-1:0] keys;
	logic plot;
	coord_x_t x;
	coord_y_t y;
	colour_t colour;
	score_t score;
	lives_t lives_left;

	int errors;
	int cycle;
	int tick_count; // ticks seen since reset
	int exp_score;
	int exp_lost;
	int prev_stamp;
	bit need_contiguous; // end screen has no idle cycles
	coord_y_t model_y [num_columns][balls_per_column];
	coord_x_t pix_x [$]; // collected pixel stream
	coord_y_t pix_y [$];
	colour_t pix_c [$];
	int pix_t [$]; // cycle of each pixel

	tap_tapper #(
		.refresh_period(refresh_period)
	) dut_i (
		.clk(clk),
		.resetn(resetn),
		.keys(keys),
		.plot(plot),
		.x(x),
		.y(y),
		.colour(colour),
		.score(score),
		.lives_left(lives_left)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycle++;
		if (cycle >= max_cycles) begin
			$display("timeout: run passed %0d cycles", max_cycles);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// outputs sampled mid cycle, away from the edge
	always @(negedge clk) begin
		if (plot) begin
			pix_x.push_back(x);
			pix_y.push_back(y);
			pix_c.push_back(colour);
			pix_t.push_back(cycle);
		end
	end

	// ball model, one step per tick with wrap at the bottom
	always @(negedge clk) begin
		if (resetn && dut_i.tick) begin
			tick_count++;
			for (int c = 0; c < num_columns; c++)
				for (int b = 0; b < balls_per_column; b++)
					model_y[c][b] = (model_y[c][b] == screen_h - 1) ? '0 : model_y[c][b] + 1'b1;
		end
	end

	task automatic check_coord_x(input coord_x_t got, input coord_x_t exp);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED x: got %h expected %h", got, exp);
		end
	endtask

	task automatic check_coord_y(input coord_y_t got, input coord_y_t exp);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED y: got %h expected %h", got, exp);
		end
	endtask

	task automatic check_colour(input colour_t got, input colour_t exp);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED colour: got %h expected %h", got, exp);
		end
	endtask

	task automatic check_score(input score_t got, input score_t exp);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED score: got %h expected %h", got, exp);
		end
	endtask

	task automatic check_lives(input lives_t got, input lives_t exp);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED lives_left: got %h expected %h", got, exp);
		end
	endtask

	// returns on the clock edge that follows a tick, +2 ns
	task automatic wait_tick();
		@(negedge clk);
		while (!dut_i.tick)
			@(negedge clk);
		@(posedge clk);
		#2;
	endtask

	task automatic flush_pixels();
		pix_x.delete();
		pix_y.delete();
		pix_c.delete();
		pix_t.delete();
	endtask

	task automatic check_quiet();
		if (pix_x.size() != 0) begin
			errors++;
			$display("%0d pixels plotted outside a frame", pix_x.size());
		end
		flush_pixels();
	endtask

	task automatic expect_pixel(input coord_x_t ex, input coord_y_t ey, input colour_t ec);
		int stamp;
		while (pix_x.size() == 0)
			@(negedge clk);
		check_coord_x(pix_x.pop_front(), ex);
		check_coord_y(pix_y.pop_front(), ey);
		check_colour(pix_c.pop_front(), ec);
		stamp = pix_t.pop_front();
		if (need_contiguous && prev_stamp >= 0 && stamp != prev_stamp + 1) begin
			errors++;
			$display("gap in the pixel stream before cycle %0d", stamp);
		end
		prev_stamp = stamp;
	endtask

	task automatic expect_raster(input colour_t c);
		for (int yy = 0; yy < screen_h; yy++)
			for (int xx = 0; xx < screen_w; xx++)
				expect_pixel(coord_x_t'(xx), coord_y_t'(yy), c);
	endtask

	task automatic expect_ball(input int c, input int b);
		for (int i = 0; i < ball_size * ball_size; i++)
			expect_pixel(coord_x_t'(column_x[c] + i % ball_size),
				coord_y_t'(model_y[c][b] + i / ball_size), ball_colour[c][b]);
	endtask

	// border only, key level decides the colour
	task automatic expect_hitbox(input int c);
		colour_t hc;
		hc = keys[c] ? colour_hitbox_off : colour_hitbox_on;
		for (int r = 0; r < hitbox_size; r++)
			for (int i = 0; i < hitbox_size; i++)
				if (r == 0 || r == hitbox_size - 1 || i == 0 || i == hitbox_size - 1)
					expect_pixel(coord_x_t'(column_x[c] - 1 + i), coord_y_t'(hitbox_top + r), hc);
	endtask

	task automatic check_frame();
		expect_raster(colour_clear);
		for (int c = 0; c < num_columns; c++) begin
			for (int b = 0; b < balls_per_column; b++)
				expect_ball(c, b);
			expect_hitbox(c);
		end
	endtask

	// model applies the hit rule when the key goes down
	task automatic key_down(input int c);
		int hit;
		hit = -1;
		for (int b = balls_per_column - 1; b >= 0; b--)
			if (model_y[c][b] >= hit_lo && model_y[c][b] <= hit_hi)
				hit = b;
		if (hit >= 0) begin
			model_y[c][hit] = ball_restart_y;
			exp_score++;
		end else begin
			exp_lost++;
		end
		@(posedge clk);
		#2;
		keys[c] = 1'b0;
	endtask

	task automatic key_up(input int c);
		@(posedge clk);
		#2;
		keys[c] = 1'b1;
	endtask

	task automatic press_key(input int c);
		key_down(c);
		repeat (5) @(posedge clk); // > 3 cycle sync plus edge
		#2;
		keys[c] = 1'b1;
		repeat (4) @(posedge clk); // high long enough for the next edge
		#2;
	endtask

	task automatic test_reset();
		check_score(score, '0);
		check_lives(lives_left, max_lives);
		wait_tick();
		check_quiet(); // nothing plotted before the first frame
		check_score(score, '0);
		check_lives(lives_left, max_lives);
	endtask

	task automatic test_first_frame();
		check_frame(); // balls at origin + 1
	endtask

	task automatic test_miss();
		press_key(0); // column 0 at 6, 36, 66, 96
		check_score(score, score_t'(exp_score));
		check_lives(lives_left, lives_t'(max_lives - exp_lost));
		wait_tick();
		check_quiet();
	endtask

	task automatic test_hit();
		while (tick_count < 12)
			wait_tick();
		press_key(2); // ball 3 of column 2 sits at 97
		check_score(score, score_t'(exp_score));
		check_lives(lives_left, lives_t'(max_lives - exp_lost));
		wait_tick();
		flush_pixels();
		check_frame();
	endtask

	task automatic test_hitbox_colour();
		key_down(1); // held across the whole next frame
		wait_tick();
		flush_pixels();
		check_frame();
		key_up(1);
		check_score(score, score_t'(exp_score));
	endtask

	task automatic test_game_over();
		for (int i = 0; i < 44; i++)
			press_key(0);
		check_lives(lives_left, lives_t'(max_lives - exp_lost));
		check_score(score, score_t'(exp_score));
		need_contiguous = 1'b1;
		prev_stamp = -1;
		expect_raster(colour_end);
		expect_raster(colour_end); // wraps straight into the next one
	endtask

	initial begin
		clk = 1'b0;
		resetn = 1'b0;
		keys = '1; // idle high
		errors = 0;
		cycle = 0;
		tick_count = 0;
		exp_score = 0;
		exp_lost = 0;
		prev_stamp = -1;
		need_contiguous = 1'b0;
		for (int c = 0; c < num_columns; c++)
			for (int b = 0; b < balls_per_column; b++)
				model_y[c][b] = ball_origin[c][b];
		repeat (4) @(posedge clk);
		#2;
		resetn = 1'b1;

		test_reset();
		test_first_frame();
		test_miss();
		test_hit();
		test_hitbox_colour();
		test_game_over();

		$display("errors: %0d checks, %0d assertions", errors, dut_i.asrt_i.fail_count);
		if (errors == 0 && dut_i.asrt_i.fail_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// ==== tb/tap_tapper_assertions.sv ====
module tap_tapper_assertions
	import tap_pkg::*;
(
	input logic clk,
	input logic resetn,
	input logic plot,
	input score_t score,
	input lives_t lives_left
);

	timeunit 1ns;
	timeprecision 100ps;

	int fail_count = 0; // failed assertions so far

	// painter output held quiet in reset
	a_plot_reset: assert property (@(posedge clk) !resetn |-> !plot)
		else begin
			fail_count++;
			$error("plot high while resetn low");
		end

	// score only climbs
	a_score_mono: assert property (@(posedge clk) disable iff (!resetn) score >= $past(score))
		else begin
			fail_count++;
			$error("score decreased");
		end

	// end screen stream never stops
	a_end_stream: assert property (@(posedge clk) disable iff (!resetn)
		$past(lives_left) == '0 |-> !$fell(plot))
		else begin
			fail_count++;
			$error("plot fell after game over");
		end

endmodule

bind tap_tapper tap_tapper_assertions asrt_i (
	.clk(clk),
	.resetn(resetn),
	.plot(plot),
	.score(score),
	.lives_left(lives_left)
);

// ==== logic/tap_tapper.sv ====
module tap_tapper
	import tap_pkg::*;
#(
	parameter int refresh_period = refresh_period_default
) (
	input  logic clk,
	input  logic resetn,
	input  logic [num_columns-1:0] keys, // active low, bit c is column c
	output logic plot,
	output coord_x_t x,
	output coord_y_t y,
	output colour_t colour,
	output score_t score,
	output lives_t lives_left
);

	logic tick;
	logic start;
	logic done;
	draw_op_t op;
	col_idx_t col;
	ball_idx_t ball;
	coord_y_t [num_columns*balls_per_column-1:0] all_y; // column c at c*4
	score_t col_score [num_columns];
	lives_t col_lost [num_columns];
	lives_t total_lost;

	frame_tick #(
		.refresh_period(refresh_period)
	) tick_i (
		.clk(clk),
		.resetn(resetn),
		.tick(tick)
	);

	for (genvar c = 0; c < num_columns; c++) begin : g_col
		ball_column #(
			.col(c)
		) column_i (
			.clk(clk),
			.resetn(resetn),
			.tick(tick),
			.key(keys[c]),
			.ball_y(all_y[c*balls_per_column +: balls_per_column]),
			.score(col_score[c]),
			.lost(col_lost[c])
		);
	end

	assign score = col_score[0] + col_score[1] + col_score[2];
	assign total_lost = col_lost[0] + col_lost[1] + col_lost[2];
	// misses keep counting after game over, clamp at zero
	assign lives_left = (total_lost >= max_lives) ? '0 : max_lives - total_lost;

	frame_sequencer seq_i (
		.clk(clk),
		.resetn(resetn),
		.tick(tick),
		.done(done),
		.total_lost(total_lost),
		.start(start),
		.op(op),
		.col(col),
		.ball(ball)
	);

	pixel_painter painter_i (
		.clk(clk),
		.resetn(resetn),
		.start(start),
		.op(op),
		.col(col),
		.ball(ball),
		.ball_y(all_y),
		.keys(keys),
		.plot(plot),
		.x(x),
		.y(y),
		.colour(colour),
		.done(done)
	);

endmodule

// ==== logic/pixel_painter.sv ====
module pixel_painter
	import tap_pkg::*;
(
	input  logic clk,
	input  logic resetn,
	input  logic start,
	input  draw_op_t op,
	input  col_idx_t col,
	input  ball_idx_t ball,
	input  coord_y_t [num_columns*balls_per_column-1:0] ball_y,
	input  logic [num_columns-1:0] keys, // active low, held level
	output logic plot,
	output coord_x_t x,
	output coord_y_t y,
	output colour_t colour,
	output logic done
);

	logic active; // raster counter running
	draw_op_t op_q;
	coord_x_t org_x; // top left of the shape
	coord_y_t org_y;
	colour_t colour_q;
	coord_x_t cx; // offset inside the shape
	coord_y_t cy;
	coord_x_t x_last;
	coord_y_t y_last;
	coord_x_t nx;
	coord_y_t ny;
	logic edge_row;
	logic last_px;
	logic end_running;
	logic [3:0] ball_sel; // flat index into ball_y

	assign ball_sel = 4'(int'(col) * balls_per_column + int'(ball));

	// end raster already loops by itself, a repeat start just rides along
	assign end_running = active && op_q == op_end && op == op_end;

	// shape extent and raster step
	always_comb begin
		case (op_q)
			op_ball: begin
				x_last = coord_x_t'(ball_size - 1);
				y_last = coord_y_t'(ball_size - 1);
			end
			op_hitbox: begin
				x_last = coord_x_t'(hitbox_size - 1);
				y_last = coord_y_t'(hitbox_size - 1);
			end
			default: begin // clear and end, full screen
				x_last = coord_x_t'(screen_w - 1);
				y_last = coord_y_t'(screen_h - 1);
			end
		endcase
		edge_row = (cy == '0) || (cy == y_last);
		last_px = (cx == x_last) && (cy == y_last);
		if (cx == x_last) begin
			nx = '0; // next row
			ny = cy + 1'b1;
		end else if (op_q == op_hitbox && !edge_row) begin
			nx = x_last; // hollow outline, jump to right side
			ny = cy;
		end else begin
			nx = cx + 1'b1;
			ny = cy;
		end
	end

	// op parameters latched at start, pixel data registers
	always_ff @(posedge clk) begin
		if (start && !end_running) begin
			op_q <= op;
			case (op)
				op_ball: begin
					org_x <= column_x[col];
					org_y <= ball_y[ball_sel]; // live position at start
					colour_q <= ball_colour[col][ball];
				end
				op_hitbox: begin
					org_x <= column_x[col] - 1'b1; // one px border around the ball
					org_y <= hitbox_top;
					colour_q <= keys[col] ? colour_hitbox_off : colour_hitbox_on;
				end
				op_end: begin
					org_x <= '0;
					org_y <= '0;
					colour_q <= colour_end;
				end
				default: begin
					org_x <= '0;
					org_y <= '0;
					colour_q <= colour_clear;
				end
			endcase
		end
		x <= org_x + cx;
		y <= org_y + cy;
		colour <= colour_q;
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			active <= 1'b0;
			cx <= '0;
			cy <= '0;
			plot <= 1'b0;
			done <= 1'b0;
		end else begin
			plot <= active; // one pixel per active cycle
			done <= active && last_px; // lines up with the last pixel
			if (start && !end_running) begin
				active <= 1'b1;
				cx <= '0;
				cy <= '0;
			end else if (active) begin
				if (last_px) begin
					cx <= '0;
					cy <= '0;
					active <= (op_q == op_end); // end screen wraps forever
				end else begin
					cx <= nx;
					cy <= ny;
				end
			end
		end
	end

endmodule

// ==== logic/frame_sequencer.sv ====
module frame_sequencer
	import tap_pkg::*;
(
	input  logic clk,
	input  logic resetn,
	input  logic tick,
	input  logic done, // painter finished current op
	input  lives_t total_lost,
	output logic start,
	output draw_op_t op,
	output col_idx_t col,
	output ball_idx_t ball
);

	seq_state_t state;
	logic game_over;

	assign game_over = (total_lost >= max_lives);

	// each start goes out the cycle after the painter's done
	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			state <= st_wait;
			start <= 1'b0;
			op <= op_clear;
			col <= '0;
			ball <= '0;
		end else begin
			start <= 1'b0; // single cycle strobe
			if (game_over && state != st_end) begin
				state <= st_end; // from anywhere, aborts the frame
				op <= op_end;
				start <= 1'b1;
			end else begin
				case (state)
					st_wait: begin
						if (tick) begin // ticks mid frame are ignored here
							state <= st_clear;
							op <= op_clear;
							col <= '0;
							ball <= '0;
							start <= 1'b1;
						end
					end
					st_clear: begin
						if (done) begin
							state <= st_ball;
							op <= op_ball;
							start <= 1'b1;
						end
					end
					st_ball: begin
						if (done) begin
							start <= 1'b1;
							if (ball == ball_idx_t'(balls_per_column - 1)) begin
								state <= st_hitbox; // column done, outline next
								op <= op_hitbox;
							end else begin
								ball <= ball + 1'b1;
							end
						end
					end
					st_hitbox: begin
						if (done) begin
							if (col == col_idx_t'(num_columns - 1)) begin
								state <= st_wait; // frame complete
							end else begin
								col <= col + 1'b1;
								ball <= '0;
								state <= st_ball;
								op <= op_ball;
								start <= 1'b1;
							end
						end
					end
					st_end: begin
						if (done)
							start <= 1'b1; // keep the red screen going
					end
					default: state <= st_wait;
				endcase
			end
		end
	end

endmodule

// ==== logic/ball_column.sv ====
module ball_column
	import tap_pkg::*;
#(
	parameter int col = 0 // picks the origin row of the table
) (
	input  logic clk,
	input  logic resetn,
	input  logic tick,
	input  logic key, // active low
	output coord_y_t [balls_per_column-1:0] ball_y,
	output score_t score,
	output lives_t lost
);

	logic key_s1;
	logic key_s2; // synchronized level
	logic key_d; // previous synchronized level
	logic press;
	logic hit_any;
	ball_idx_t hit_idx;

	// two flop sync then falling edge detect
	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			key_s1 <= 1'b1; // idle high
			key_s2 <= 1'b1;
			key_d <= 1'b1;
		end else begin
			key_s1 <= key;
			key_s2 <= key_s1;
			key_d <= key_s2;
		end
	end

	assign press = key_d & ~key_s2; // high for one cycle per press

	// lowest index ball inside the hit window wins
	always_comb begin
		hit_any = 1'b0;
		hit_idx = '0;
		for (int b = balls_per_column - 1; b >= 0; b--) begin
			if (ball_y[b] >= hit_lo && ball_y[b] <= hit_hi) begin
				hit_any = 1'b1;
				hit_idx = ball_idx_t'(b);
			end
		end
	end

	// fall counters
	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			for (int b = 0; b < balls_per_column; b++) begin
				ball_y[b] <= ball_origin[col][b];
			end
		end else begin
			for (int b = 0; b < balls_per_column; b++) begin
				if (press && hit_any && hit_idx == ball_idx_t'(b)) begin
					ball_y[b] <= ball_restart_y; // hit beats the tick
				end else if (tick) begin
					if (ball_y[b] == coord_y_t'(screen_h - 1))
						ball_y[b] <= '0; // wrap to top
					else
						ball_y[b] <= ball_y[b] + 1'b1;
				end
			end
		end
	end

	// score on hit, lost life on a miss
	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			score <= '0;
			lost <= '0;
		end else if (press) begin
			if (hit_any)
				score <= score + 1'b1;
			else
				lost <= lost + 1'b1;
		end
	end

endmodule

// ==== logic/frame_tick.sv ====
module frame_tick
	import tap_pkg::*;
#(
	parameter int refresh_period = refresh_period_default
) (
	input  logic clk,
	input  logic resetn,
	output logic tick
);

	logic [$clog2(refresh_period+1)-1:0] count; // cycles left in this period

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			count <= $bits(count)'(refresh_period - 1);
		end else if (count == '0) begin
			count <= $bits(count)'(refresh_period - 1); // reload
		end else begin
			count <= count - 1'b1;
		end
	end

	// one cycle high per period, motion clock of the game
	assign tick = (count == '0);

endmodule

// ==== logic/tap_pkg.sv ====
package tap_pkg;

	typedef logic [7:0] coord_x_t; // screen column
	typedef logic [6:0] coord_y_t; // screen row
	typedef logic [2:0] colour_t; // {r, g, b}
	typedef logic [15:0] score_t;
	typedef logic [7:0] lives_t;
	typedef logic [1:0] col_idx_t;
	typedef logic [1:0] ball_idx_t;

	// what the painter is asked to draw
	typedef enum logic [2:0] {
		op_clear,
		op_ball,
		op_hitbox,
		op_end
	} draw_op_t;

	typedef enum logic [2:0] {
		st_wait, // idle until next refresh tick
		st_clear,
		st_ball,
		st_hitbox,
		st_end // game over, terminal
	} seq_state_t;

	localparam int screen_w = 160;
	localparam int screen_h = 120;

	localparam int num_columns = 3;
	localparam int balls_per_column = 4;

	localparam int ball_size = 4;
	localparam int hitbox_size = 6;
	localparam coord_y_t hitbox_top = 7'd100;

	// hit window, inclusive on both ends
	localparam coord_y_t hit_lo = 7'd97;
	localparam coord_y_t hit_hi = 7'd106;
	localparam coord_y_t ball_restart_y = 7'd5; // where a hit ball respawns
	localparam lives_t max_lives = 8'd45;

	localparam int refresh_period_default = 833333; // ~60 Hz off 50 MHz

	localparam colour_t colour_clear = 3'd7; // white
	localparam colour_t colour_end = 3'd4; // red
	localparam colour_t colour_hitbox_on = 3'd4;
	localparam colour_t colour_hitbox_off = 3'd0;

	localparam coord_x_t column_x [num_columns] = '{8'd56, 8'd71, 8'd86};

	// reset y of every ball, staggered per column
	localparam coord_y_t ball_origin [num_columns][balls_per_column] = '{
		'{7'd5, 7'd35, 7'd65, 7'd95},
		'{7'd0, 7'd30, 7'd60, 7'd90},
		'{7'd10, 7'd40, 7'd65, 7'd85}
	};

	localparam colour_t ball_colour [num_columns][balls_per_column] = '{
		'{3'd1, 3'd2, 3'd3, 3'd4},
		'{3'd1, 3'd4, 3'd3, 3'd2},
		'{3'd1, 3'd4, 3'd5, 3'd6}
	};

endpackage
